/* Makefile */
# Verilator build and run for the decode-and-issue testbench

VERILATOR ?= verilator
TOP       ?= decode_issue_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TAG  ?= RESULT: FAIL
PASS_TAG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TAG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TAG)" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/decode_issue_pkg.sv */
// Micro-op set, op-subset masks and widths for the decode-and-issue stage.
// The micro-op order fixes each op's bit position in an op_vec_t mask.
`default_nettype none

package decode_issue_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_OPS    = 8;

  // -------------------------------------------------------------------
  // Micro-ops
  // -------------------------------------------------------------------

  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_ADDI = 4'd1,
    UOP_MUL  = 4'd2,
    UOP_LW   = 4'd3,
    UOP_SW   = 4'd4,
    UOP_JAL  = 4'd5,
    UOP_JALR = 4'd6,
    UOP_BNE  = 4'd7,
    UOP_NONE = 4'd8
  } uop_e;

  // -------------------------------------------------------------------
  // Op-subset masks, one bit per real micro-op
  // -------------------------------------------------------------------

  typedef logic [NUM_OPS-1:0] op_vec_t;

  localparam op_vec_t OP_ADD_VEC  = 8'b0000_0001;
  localparam op_vec_t OP_ADDI_VEC = 8'b0000_0010;
  localparam op_vec_t OP_MUL_VEC  = 8'b0000_0100;
  localparam op_vec_t OP_LW_VEC   = 8'b0000_1000;
  localparam op_vec_t OP_SW_VEC   = 8'b0001_0000;
  localparam op_vec_t OP_JAL_VEC  = 8'b0010_0000;
  localparam op_vec_t OP_JALR_VEC = 8'b0100_0000;
  localparam op_vec_t OP_BNE_VEC  = 8'b1000_0000;
  localparam op_vec_t OP_ALL_VEC  = 8'b1111_1111;

  // Unsupported encodings map to an empty mask
  function automatic op_vec_t uop_to_vec(input uop_e uop);
    op_vec_t vec;
    case (uop)
      UOP_ADD:  vec = OP_ADD_VEC;
      UOP_ADDI: vec = OP_ADDI_VEC;
      UOP_MUL:  vec = OP_MUL_VEC;
      UOP_LW:   vec = OP_LW_VEC;
      UOP_SW:   vec = OP_SW_VEC;
      UOP_JAL:  vec = OP_JAL_VEC;
      UOP_JALR: vec = OP_JALR_VEC;
      UOP_BNE:  vec = OP_BNE_VEC;
      default:  vec = '0;
    endcase
    return vec;
  endfunction

endpackage

`default_nettype wire

/* design/decode_issue_unit.sv */
// Decode-and-issue stage: fetch val/rdy in, NUM_PIPES execute lanes out.
// Issue is combinational in the cycle a fetch message is accepted.
// No bypass from the execute pipes; results come back on the c_ strobe.
`default_nettype none

module decode_issue_unit
  import decode_issue_pkg::*;
#(
  parameter int                            NUM_PIPES    = 3,
  parameter int                            SEQ_W        = 5,
  parameter op_vec_t [NUM_PIPES-1:0]       PIPE_SUBSETS = {NUM_PIPES{OP_ALL_VEC}}
) (
  input  logic                                 clk,
  input  logic                                 rst,
  // Fetch
  input  logic                                 f_val,
  output logic                                 f_rdy,
  input  logic [XLEN-1:0]                      f_inst,
  input  logic [XLEN-1:0]                      f_pc,
  input  logic [SEQ_W-1:0]                     f_seq_num,
  // Execute lanes
  output logic [NUM_PIPES-1:0]                 x_val,
  input  logic [NUM_PIPES-1:0]                 x_rdy,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_pc,
  output logic [NUM_PIPES-1:0][SEQ_W-1:0]      x_seq_num,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_op1,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_op2,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_imm,
  output logic [NUM_PIPES-1:0][REG_ADDR_W-1:0] x_waddr,
  output uop_e [NUM_PIPES-1:0]                 x_uop,
  // Completion
  input  logic                                 c_val,
  input  logic [REG_ADDR_W-1:0]                c_waddr,
  input  logic [XLEN-1:0]                      c_wdata,
  input  logic                                 c_wen
);

  uop_e                  uop;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  writes_rd;
  logic [XLEN-1:0]       rdata0;
  logic [XLEN-1:0]       rdata1;
  logic                  stall;
  logic                  issue;
  logic                  c_write;

  assign c_write = c_val && c_wen;

  inst_decoder u_decoder (
    .inst      (f_inst),
    .uop       (uop),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .uses_rs1  (uses_rs1),
    .uses_rs2  (uses_rs2),
    .writes_rd (writes_rd)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (rs1),
    .raddr1 (rs2),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (c_write),
    .waddr  (c_waddr),
    .wdata  (c_wdata)
  );

  // Clears by address on any completion
  hazard_scoreboard u_scoreboard (
    .clk        (clk),
    .rst        (rst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .uses_rs1   (uses_rs1),
    .uses_rs2   (uses_rs2),
    .writes_rd  (writes_rd),
    .issue      (issue),
    .clear      (c_val),
    .clear_addr (c_waddr),
    .stall      (stall)
  );

  issue_router #(
    .NUM_PIPES    (NUM_PIPES),
    .SEQ_W        (SEQ_W),
    .PIPE_SUBSETS (PIPE_SUBSETS)
  ) u_router (
    .f_val     (f_val),
    .f_rdy     (f_rdy),
    .f_pc      (f_pc),
    .f_seq_num (f_seq_num),
    .uop       (uop),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .imm       (imm),
    .rd        (rd),
    .writes_rd (writes_rd),
    .stall     (stall),
    .issue     (issue),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_seq_num (x_seq_num),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop)
  );

endmodule

`default_nettype wire

/* design/hazard_scoreboard.sv */
// One pending bit per architectural register, tracked by address only.
// A clear in the current cycle already unblocks readers of that register.
// Set wins over clear when both hit the same register in one cycle.
`default_nettype none

module hazard_scoreboard
  import decode_issue_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic                  uses_rs1,
  input  logic                  uses_rs2,
  input  logic                  writes_rd,
  input  logic                  issue,
  input  logic                  clear,
  input  logic [REG_ADDR_W-1:0] clear_addr,
  output logic                  stall
);

  localparam int NUM_REGS = 2**REG_ADDR_W;

  logic [NUM_REGS-1:0] pending;
  logic [NUM_REGS-1:0] pending_nxt;
  logic [NUM_REGS-1:0] busy;

  always_comb begin
    pending_nxt = pending;
    if (clear) begin
      pending_nxt[clear_addr] = 1'b0;
    end
    // x0 never becomes pending
    if (issue && writes_rd && rd != '0) begin
      pending_nxt[rd] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= pending_nxt;
    end
  end

  // Bits being cleared this cycle no longer block
  always_comb begin
    busy = pending;
    if (clear) begin
      busy[clear_addr] = 1'b0;
    end
  end

  assign stall = (uses_rs1  && rs1 != '0 && busy[rs1])
              || (uses_rs2  && rs2 != '0 && busy[rs2])
              || (writes_rd && rd  != '0 && busy[rd]);

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
// Decodes the TinyRV1 subset: add, addi, mul, lw, sw, jal, jalr, bne.
// Any other word gives UOP_NONE with all usage flags low and a zero imm.
// Register fields are passed through raw; the flags say which are real.
`default_nettype none

module inst_decoder
  import decode_issue_pkg::*;
(
  input  logic [XLEN-1:0]       inst,
  output uop_e                  uop,
  output logic [REG_ADDR_W-1:0] rs1,
  output logic [REG_ADDR_W-1:0] rs2,
  output logic [REG_ADDR_W-1:0] rd,
  output logic [XLEN-1:0]       imm,
  output logic                  uses_rs1,
  output logic                  uses_rs2,
  output logic                  writes_rd
);

  // Major opcodes used by the subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  // -------------------------------------------------------------------
  // Immediate formats
  // -------------------------------------------------------------------

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // -------------------------------------------------------------------
  // Op select and register usage
  // -------------------------------------------------------------------

  always_comb begin
    uop       = UOP_NONE;
    imm       = '0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;

    case (opcode)
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          uop = UOP_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
          uop = UOP_MUL;
        end
        if (uop != UOP_NONE) begin
          uses_rs1  = 1'b1;
          uses_rs2  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          uop       = UOP_ADDI;
          imm       = imm_i;
          uses_rs1  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          uop       = UOP_LW;
          imm       = imm_i;
          uses_rs1  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          uop      = UOP_SW;
          imm      = imm_s;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      OPC_JAL: begin
        uop       = UOP_JAL;
        imm       = imm_j;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          uop       = UOP_JALR;
          imm       = imm_i;
          uses_rs1  = 1'b1;
          writes_rd = 1'b1;
        end
      end
      OPC_BRANCH: begin
        // Only bne among the branches
        if (funct3 == 3'b001) begin
          uop      = UOP_BNE;
          imm      = imm_b;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      default: begin
        uop = UOP_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/issue_router.sv */
// Forms the execute message and steers it to the lowest-numbered ready pipe
// whose op subset holds the micro-op. Lane valid depends on lane ready.
// Unsupported words are consumed with no lane raised.
`default_nettype none

module issue_router
  import decode_issue_pkg::*;
#(
  parameter int                            NUM_PIPES    = 3,
  parameter int                            SEQ_W        = 5,
  parameter op_vec_t [NUM_PIPES-1:0]       PIPE_SUBSETS = {NUM_PIPES{OP_ALL_VEC}}
) (
  input  logic                                 f_val,
  output logic                                 f_rdy,
  input  logic [XLEN-1:0]                      f_pc,
  input  logic [SEQ_W-1:0]                     f_seq_num,
  input  uop_e                                 uop,
  input  logic [XLEN-1:0]                      rdata0,
  input  logic [XLEN-1:0]                      rdata1,
  input  logic [XLEN-1:0]                      imm,
  input  logic [REG_ADDR_W-1:0]                rd,
  input  logic                                 writes_rd,
  input  logic                                 stall,
  output logic                                 issue,
  output logic [NUM_PIPES-1:0]                 x_val,
  input  logic [NUM_PIPES-1:0]                 x_rdy,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_pc,
  output logic [NUM_PIPES-1:0][SEQ_W-1:0]      x_seq_num,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_op1,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_op2,
  output logic [NUM_PIPES-1:0][XLEN-1:0]       x_imm,
  output logic [NUM_PIPES-1:0][REG_ADDR_W-1:0] x_waddr,
  output uop_e [NUM_PIPES-1:0]                 x_uop
);

  op_vec_t               uop_vec;
  logic                  is_none;
  logic                  uses_op2;
  logic [XLEN-1:0]       op1;
  logic [XLEN-1:0]       op2;
  logic [REG_ADDR_W-1:0] waddr;
  logic [NUM_PIPES-1:0]  cand;
  logic [NUM_PIPES-1:0]  sel;
  logic                  found;

  // -------------------------------------------------------------------
  // Operands
  // -------------------------------------------------------------------

  assign uop_vec  = uop_to_vec(uop);
  assign is_none  = (uop == UOP_NONE);
  assign uses_op2 = |(uop_vec & (OP_ADD_VEC | OP_MUL_VEC | OP_SW_VEC | OP_BNE_VEC));

  // jal links from the pc
  assign op1   = (uop == UOP_JAL) ? f_pc : rdata0;
  assign op2   = uses_op2 ? rdata1 : '0;
  assign waddr = writes_rd ? rd : '0;

  // -------------------------------------------------------------------
  // Pipe select, lowest index first
  // -------------------------------------------------------------------

  always_comb begin
    sel   = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      cand[i] = x_rdy[i] && (|(PIPE_SUBSETS[i] & uop_vec));
      if (cand[i] && !found) begin
        sel[i] = 1'b1;
        found  = 1'b1;
      end
    end
  end

  assign f_rdy = is_none || (!stall && found);
  assign issue = f_val && !is_none && !stall && found;
  assign x_val = issue ? sel : '0;

  // Same message on every lane, only x_val tells them apart
  always_comb begin
    for (int i = 0; i < NUM_PIPES; i++) begin
      x_pc[i]      = f_pc;
      x_seq_num[i] = f_seq_num;
      x_op1[i]     = op1;
      x_op2[i]     = op2;
      x_imm[i]     = imm;
      x_waddr[i]   = waddr;
      x_uop[i]     = uop;
    end
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// 32 x 32 register file, two read ports and one write port.
// x0 always reads zero. A same-cycle write is forwarded to the reads.
`default_nettype none

module reg_file
  import decode_issue_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] raddr0,
  input  logic [REG_ADDR_W-1:0] raddr1,
  output logic [XLEN-1:0]       rdata0,
  output logic [XLEN-1:0]       rdata1,
  input  logic                  wen,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]       wdata
);

  logic [XLEN-1:0] regs [2**REG_ADDR_W];
  logic            wr_live;

  assign wr_live = wen && (waddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wr_live) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through, so a completing value is usable in the same cycle
  assign rdata0 = (wr_live && waddr == raddr0) ? wdata : regs[raddr0];
  assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verification
design/decode_issue_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_scoreboard.sv
design/issue_router.sv
design/decode_issue_unit.sv
verification/decode_issue_tb.sv

/* verification/issue_model.svh */
// Reference model for the decode-and-issue testbench, included in its module.
// Relies on NUM_PIPES from the including scope. Immediates are passed unencoded.
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Builds an instruction word; UOP_NONE gives a word outside the subset
function automatic logic [31:0] encode_inst(input uop_e op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [31:0] imm);
  logic [31:0] word;
  case (op)
    UOP_ADD:  word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    UOP_MUL:  word = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
    UOP_ADDI: word = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    UOP_LW:   word = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    UOP_SW:   word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    UOP_JAL:  word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    UOP_JALR: word = {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
    UOP_BNE:  word = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
    default:  word = 32'hffff_ffff;
  endcase
  return word;
endfunction

// Sign-extended immediate as the op's format carries it
function automatic logic [31:0] expect_imm(input uop_e op, input logic [31:0] imm);
  case (op)
    UOP_ADDI, UOP_LW, UOP_JALR, UOP_SW: return {{20{imm[11]}}, imm[11:0]};
    UOP_BNE: return {{19{imm[12]}}, imm[12:1], 1'b0};
    UOP_JAL: return {{11{imm[20]}}, imm[20:1], 1'b0};
    default: return 32'd0;
  endcase
endfunction

function automatic logic [31:0] expect_op1(input uop_e op, input logic [31:0] pc,
                                           input logic [31:0] rs1_val);
  return (op == UOP_JAL) ? pc : rs1_val;
endfunction

function automatic logic [31:0] expect_op2(input uop_e op, input logic [31:0] rs2_val);
  if (op == UOP_ADD || op == UOP_MUL || op == UOP_SW || op == UOP_BNE) begin
    return rs2_val;
  end
  return 32'd0;
endfunction

// Stores and branches write no register
function automatic logic [4:0] expect_waddr(input uop_e op, input logic [4:0] rd);
  return (op == UOP_SW || op == UOP_BNE) ? 5'd0 : rd;
endfunction

// Lowest ready pipe whose subset holds the op, -1 if none
function automatic int expect_lane(input uop_e op, input logic [NUM_PIPES-1:0] rdy,
                                   input op_vec_t [NUM_PIPES-1:0] subsets);
  for (int i = 0; i < NUM_PIPES; i++) begin
    if (rdy[i] && |(subsets[i] & uop_to_vec(op))) begin
      return i;
    end
  end
  return -1;
endfunction

`endif

/* verification/decode_issue_tb.sv */
// Directed testbench for decode_issue_unit on three pipes where pipe 2 takes only mul.
// Inputs change 1 unit after the rising edge and outputs are sampled just before it.
`default_nettype none

module decode_issue_tb
  import decode_issue_pkg::*;
();

  localparam int NUM_PIPES = 3;
  localparam int SEQ_W     = 5;
  localparam op_vec_t [NUM_PIPES-1:0] PIPE_SUBSETS = {OP_MUL_VEC, OP_ALL_VEC, OP_ALL_VEC};

  logic                                 clk;
  logic                                 rst;
  logic                                 f_val;
  logic                                 f_rdy;
  logic [XLEN-1:0]                      f_inst;
  logic [XLEN-1:0]                      f_pc;
  logic [SEQ_W-1:0]                     f_seq_num;
  logic [NUM_PIPES-1:0]                 x_val;
  logic [NUM_PIPES-1:0]                 x_rdy;
  logic [NUM_PIPES-1:0][XLEN-1:0]       x_pc;
  logic [NUM_PIPES-1:0][SEQ_W-1:0]      x_seq_num;
  logic [NUM_PIPES-1:0][XLEN-1:0]       x_op1;
  logic [NUM_PIPES-1:0][XLEN-1:0]       x_op2;
  logic [NUM_PIPES-1:0][XLEN-1:0]       x_imm;
  logic [NUM_PIPES-1:0][REG_ADDR_W-1:0] x_waddr;
  uop_e [NUM_PIPES-1:0]                 x_uop;
  logic                                 c_val;
  logic [REG_ADDR_W-1:0]                c_waddr;
  logic [XLEN-1:0]                      c_wdata;
  logic                                 c_wen;

  // Expected register contents and the message on the fetch port
  logic [XLEN-1:0]       reg_mirror [32];
  uop_e                  cur_op;
  logic [REG_ADDR_W-1:0] cur_rd;
  logic [REG_ADDR_W-1:0] cur_rs1;
  logic [REG_ADDR_W-1:0] cur_rs2;
  logic [XLEN-1:0]       cur_imm;
  int                    errors;
  int                    test_start_errors;
  int                    tests_run;
  int                    tests_failed;

  decode_issue_unit #(
    .NUM_PIPES    (NUM_PIPES),
    .SEQ_W        (SEQ_W),
    .PIPE_SUBSETS (PIPE_SUBSETS)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .f_val     (f_val),
    .f_rdy     (f_rdy),
    .f_inst    (f_inst),
    .f_pc      (f_pc),
    .f_seq_num (f_seq_num),
    .x_val     (x_val),
    .x_rdy     (x_rdy),
    .x_pc      (x_pc),
    .x_seq_num (x_seq_num),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_waddr   (x_waddr),
    .x_uop     (x_uop),
    .c_val     (c_val),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata),
    .c_wen     (c_wen)
  );

  always #50 clk = ~clk;

  `include "issue_model.svh"

  // -------------------------------------------------------------------
  // Cycle helpers and checks
  // -------------------------------------------------------------------

  task automatic wait_sample_point();
    #98;
  endtask

  task automatic next_drive_point();
    @(posedge clk);
    #1;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic present(input uop_e op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [31:0] imm);
    cur_op    = op;
    cur_rd    = rd;
    cur_rs1   = rs1;
    cur_rs2   = rs2;
    cur_imm   = imm;
    f_val     = 1'b1;
    f_inst    = encode_inst(op, rd, rs1, rs2, imm);
    f_pc      = f_pc + 32'd4;
    f_seq_num = f_seq_num + SEQ_W'(1);
  endtask

  // Drives a completion for the current cycle and mirrors any write other than x0
  task automatic complete(input logic [4:0] addr, input logic [31:0] data, input logic wen);
    c_val   = 1'b1;
    c_wen   = wen;
    c_waddr = addr;
    c_wdata = data;
    if (wen && addr != 5'd0) begin
      reg_mirror[addr] = data;
    end
  endtask

  task automatic strobe_complete(input logic [4:0] addr, input logic [31:0] data,
                                 input logic wen);
    complete(addr, data, wen);
    next_drive_point();
    c_val = 1'b0;
    c_wen = 1'b0;
  endtask

  // Waits up to max_stall cycles for acceptance, then checks the lane
  task automatic wait_issue(input int max_stall);
    int waited;
    int lane;
    waited = 0;
    wait_sample_point();
    while (!f_rdy && waited < max_stall) begin
      next_drive_point();
      wait_sample_point();
      waited++;
    end
    lane = expect_lane(cur_op, x_rdy, PIPE_SUBSETS);
    assert (f_rdy) else begin
      $display("Timeout at %0t: %s not accepted within %0d cycles", $time, cur_op.name(),
               max_stall);
      errors++;
    end
    assert (!f_rdy || lane >= 0) else begin
      $display("Error at %0t: %s accepted with no capable ready pipe", $time, cur_op.name());
      errors++;
    end
    if (f_rdy && lane >= 0) begin
      check_eq("x_val", 32'(x_val), 32'(1) << lane);
      check_eq("x_uop", 32'(x_uop[lane]), 32'(cur_op));
      check_eq("x_op1", x_op1[lane], expect_op1(cur_op, f_pc, reg_mirror[cur_rs1]));
      check_eq("x_op2", x_op2[lane], expect_op2(cur_op, reg_mirror[cur_rs2]));
      check_eq("x_imm", x_imm[lane], expect_imm(cur_op, cur_imm));
      check_eq("x_waddr", 32'(x_waddr[lane]), 32'(expect_waddr(cur_op, cur_rd)));
      check_eq("x_pc", x_pc[lane], f_pc);
      check_eq("x_seq_num", 32'(x_seq_num[lane]), 32'(f_seq_num));
    end
    next_drive_point();
    f_val = 1'b0;
    c_val = 1'b0;
    c_wen = 1'b0;
  endtask

  task automatic hold_check(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      wait_sample_point();
      check_eq("f_rdy", 32'(f_rdy), 32'd0);
      check_eq("x_val", 32'(x_val), 32'd0);
      next_drive_point();
    end
  endtask

  // An unsupported word is taken with every lane left idle
  task automatic check_dropped();
    wait_sample_point();
    check_eq("f_rdy", 32'(f_rdy), 32'd1);
    check_eq("x_val", 32'(x_val), 32'd0);
    next_drive_point();
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - test_start_errors);
    end
  endtask

  // -------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------

  task automatic test_decode_operands();
    int i;
    start_test();
    x_rdy = '1;
    for (i = 1; i <= 8; i++) begin
      strobe_complete(5'(i), $urandom(), 1'b1);
    end
    present(UOP_ADD, 5'd10, 5'd1, 5'd2, 32'd0);
    wait_issue(0);
    present(UOP_ADDI, 5'd11, 5'd3, 5'd4, 32'hffff_fffb);
    wait_issue(0);
    present(UOP_MUL, 5'd12, 5'd4, 5'd5, 32'd0);
    wait_issue(0);
    present(UOP_LW, 5'd13, 5'd6, 5'd7, 32'd100);
    wait_issue(0);
    present(UOP_SW, 5'd0, 5'd7, 5'd8, 32'hffff_fff4);
    wait_issue(0);
    present(UOP_JAL, 5'd14, 5'd0, 5'd0, 32'hffff_f800);
    wait_issue(0);
    present(UOP_JALR, 5'd15, 5'd1, 5'd2, 32'd36);
    wait_issue(0);
    present(UOP_BNE, 5'd0, 5'd2, 5'd3, 32'hffff_fff0);
    wait_issue(0);
    for (i = 10; i <= 15; i++) begin
      strobe_complete(5'(i), 32'd0, 1'b0);
    end
    end_test("decode_operands");
  endtask

  task automatic test_pipe_select();
    start_test();
    x_rdy = 3'b111;
    present(UOP_MUL, 5'd20, 5'd1, 5'd2, 32'd0);
    wait_issue(0);
    x_rdy = 3'b100;
    present(UOP_MUL, 5'd21, 5'd3, 5'd4, 32'd0);
    wait_issue(0);
    // Pipe 2 cannot take add
    present(UOP_ADD, 5'd22, 5'd3, 5'd4, 32'd0);
    hold_check(3);
    x_rdy = 3'b111;
    wait_issue(0);
    strobe_complete(5'd20, 32'd0, 1'b0);
    strobe_complete(5'd21, 32'd0, 1'b0);
    strobe_complete(5'd22, 32'd0, 1'b0);
    end_test("pipe_select");
  endtask

  task automatic test_back_pressure();
    start_test();
    x_rdy = 3'b000;
    present(UOP_LW, 5'd23, 5'd5, 5'd0, 32'hffff_ff9c);
    hold_check(4);
    x_rdy = 3'b010;
    wait_issue(0);
    strobe_complete(5'd23, 32'd0, 1'b0);
    end_test("back_pressure");
  endtask

  task automatic test_hazards();
    start_test();
    x_rdy = 3'b111;
    present(UOP_ADD, 5'd5, 5'd1, 5'd2, 32'd0);
    wait_issue(0);
    // Second write to x5 waits for the first
    present(UOP_ADDI, 5'd5, 5'd1, 5'd0, 32'd3);
    hold_check(3);
    complete(5'd5, $urandom(), 1'b1);
    wait_issue(0);
    // Reader of x5 waits, then takes the completed value in the same cycle
    present(UOP_ADDI, 5'd6, 5'd5, 5'd0, 32'd1);
    hold_check(3);
    complete(5'd5, $urandom(), 1'b1);
    wait_issue(0);
    strobe_complete(5'd6, 32'd0, 1'b0);
    end_test("hazards");
  endtask

  task automatic test_x0_and_unsupported();
    start_test();
    x_rdy = 3'b111;
    strobe_complete(5'd0, $urandom(), 1'b1);
    present(UOP_ADDI, 5'd7, 5'd0, 5'd0, 32'd0);
    complete(5'd0, $urandom(), 1'b1);
    wait_issue(0);
    present(UOP_ADD, 5'd0, 5'd1, 5'd2, 32'd0);
    wait_issue(0);
    present(UOP_ADD, 5'd8, 5'd0, 5'd0, 32'd0);
    wait_issue(0);
    // Dropped with every pipe ready and again with none ready
    present(UOP_NONE, 5'd9, 5'd1, 5'd2, 32'd0);
    check_dropped();
    x_rdy = 3'b000;
    present(UOP_NONE, 5'd9, 5'd1, 5'd2, 32'd0);
    check_dropped();
    f_val = 1'b0;
    strobe_complete(5'd7, 32'd0, 1'b0);
    strobe_complete(5'd8, 32'd0, 1'b0);
    end_test("x0_and_unsupported");
  endtask

  initial begin
    void'($urandom(32'hc6af));
    clk        = 1'b0;
    rst        = 1'b1;
    f_val      = 1'b0;
    f_inst     = 32'd0;
    f_pc       = 32'h0000_1000;
    f_seq_num  = '0;
    x_rdy      = '0;
    c_val      = 1'b0;
    c_waddr    = '0;
    c_wdata    = 32'd0;
    c_wen      = 1'b0;
    reg_mirror = '{default: '0};
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_decode_operands();
    test_pipe_select();
    test_back_pressure();
    test_hazards();
    test_x0_and_unsupported();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
